// File: rtl/isaPkg.sv
package isaPkg;

    // Instruction fields seen by the control unit
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // R-type instructions share one opcode and split on funct
    localparam opcode_t OpRType = 6'b000000;

    // Memory operand add, I-type
    localparam opcode_t OpAddm = 6'b000001;

    // Arithmetic with overflow trap
    localparam funct_t FunctAdd = 6'b100000;
    localparam funct_t FunctSub = 6'b100010;

    // PC control
    localparam funct_t FunctBreak = 6'b001101;
    localparam funct_t FunctRte = 6'b010011;

    // Divide of two memory operands into HI and LO
    localparam funct_t FunctDivm = 6'b000101;

    // Decoded class that the sequencer branches on after decode
    typedef enum logic [2:0] {
        classAdd,
        classSub,
        classBreak,
        classRte,
        classAddm,
        classDivm,
        classIllegal
    } instrClass_t;

endpackage

// File: rtl/ctrlPkg.sv
package ctrlPkg;

    // Width of the wait timer count
    localparam int TimerWidth = 6;

    // Sequencer states, fetch and decode first, then one group per instruction
    typedef enum logic [4:0] {
        stReset,
        fetchRead,
        fetchLoad,
        decode,
        aluExec,
        aluCheck,
        aluWrite,
        breakPc,
        rtePc,
        addmAddr,
        addmRead,
        addmMdr,
        addmAdd,
        addmWrite,
        divmReadA,
        divmMdrA,
        divmReadB,
        divmRun,
        divmWrite,
        excEpc,
        excPc
    } ctrlState_t;

    typedef enum logic [2:0] {aluLoad = 3'd0, aluAdd = 3'd1, aluSub = 3'd2, aluAnd = 3'd3} aluOp_t;

    // Memory address source
    typedef enum logic [2:0] {
        pcAddr = 3'b000,
        aluOutAddr = 3'b100,
        regAAddr = 3'b101,
        regBAddr = 3'b110
    } iorDSel_t;

    typedef enum logic [1:0] {srcPc = 2'b01, srcRegA = 2'b10, srcMdr = 2'b11} aluSrcA_t;
    typedef enum logic [1:0] {srcFour = 2'b01, srcRegB = 2'b10, srcOffset = 2'b11} aluSrcB_t;

    // pcVector is the exception entry address
    typedef enum logic [1:0] {
        pcVector = 2'd0,
        pcAluResult = 2'd1,
        pcAluOut = 2'd2,
        pcEpc = 2'd3
    } pcSource_t;

    typedef enum logic [1:0] {dstRt = 2'b01, dstRd = 2'b11} regDst_t;
    typedef enum logic [2:0] {dataAluOut = 3'b100, dataMdr = 3'b111} dataSrc_t;
    typedef enum logic [1:0] {causeNone = 2'd0, causeOverflow = 2'd1, causeIllegal = 2'd2} exCause_t;

    typedef struct packed {
        logic pcWrite;
        logic irWrite;
        logic regWrite;
        logic regAWrite;
        logic regBWrite;
        logic aluOutWrite;
        logic mdrWrite;
        logic memWrite;
        logic epcWrite;
        logic hiWrite;
        logic loWrite;
    } writeEnables_t;

    // mdSrcA and mdSrcB high pick the memory side of the divider inputs
    typedef struct packed {
        iorDSel_t iorD;
        aluSrcA_t aluSrcA;
        aluSrcB_t aluSrcB;
        pcSource_t pcSource;
        regDst_t regDst;
        dataSrc_t dataSrc;
        logic mdSrcA;
        logic mdSrcB;
    } muxSelects_t;

    typedef struct packed {
        aluOp_t aluOp;
        exCause_t exCause;
        logic mdRun;
    } aluControl_t;

endpackage

// File: rtl/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder (
    input isaPkg::opcode_t opcode,
    input isaPkg::funct_t funct,
    output isaPkg::instrClass_t instrClass
);
    import isaPkg::*;

    always_comb begin
        instrClass = classIllegal;

        if (opcode == OpRType) begin
            // Only R-type looks at funct
            case (funct)
                FunctAdd:
                    instrClass = classAdd;
                FunctSub:
                    instrClass = classSub;
                FunctBreak:
                    instrClass = classBreak;
                FunctRte:
                    instrClass = classRte;
                FunctDivm:
                    instrClass = classDivm;
                default:
                    instrClass = classIllegal;
            endcase
        end else if (opcode == OpAddm) begin
            instrClass = classAddm;
        end
        // Loads, stores, branches and jumps all fall through as illegal
    end

endmodule

// File: rtl/waitTimer.sv
`timescale 1ns/1ps

module waitTimer (
    input logic clock,
    input logic reset,
    input logic timerLoad,
    input logic [ctrlPkg::TimerWidth-1:0] timerCount,
    output logic timerDone
);
    import ctrlPkg::*;

    // Zero means idle, one means last cycle of the wait
    logic [TimerWidth-1:0] count;

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (timerLoad) begin
            count <= timerCount;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign timerDone = (count == TimerWidth'(1));

    // A reload may only come on the last cycle of a wait or when idle
    noLoadWhileRunning: assert property (
        @(posedge clock) disable iff (reset)
        timerLoad |-> (count <= TimerWidth'(1))
    );

endmodule

// File: rtl/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer #(
    parameter int MemWaitCycles = 2,
    parameter int DivCycles = 32
) (
    input logic clock,
    input logic reset,
    input isaPkg::instrClass_t instrClass,
    input logic overflow,
    input logic timerDone,
    output logic timerLoad,
    output logic [ctrlPkg::TimerWidth-1:0] timerCount,
    output ctrlPkg::ctrlState_t state,
    output logic resetOut
);
    import isaPkg::*;
    import ctrlPkg::*;

    localparam logic [TimerWidth-1:0] MemCount = TimerWidth'(MemWaitCycles);
    localparam logic [TimerWidth-1:0] DivCount = TimerWidth'(DivCycles);

    ctrlState_t nextState;
    logic loadDiv;

    always_comb begin
        nextState = state;
        timerLoad = 1'b0;
        loadDiv = 1'b0;

        case (state)
            stReset: begin
                nextState = fetchRead;
                timerLoad = 1'b1;
            end
            fetchRead: begin
                if (timerDone) begin
                    nextState = fetchLoad;
                end
            end
            fetchLoad:
                nextState = decode;
            decode: begin
                case (instrClass)
                    classAdd, classSub:
                        nextState = aluExec;
                    classBreak:
                        nextState = breakPc;
                    classRte:
                        nextState = rtePc;
                    classAddm:
                        nextState = addmAddr;
                    classDivm: begin
                        nextState = divmReadA;
                        timerLoad = 1'b1;
                    end
                    // Unknown opcode or funct traps
                    default:
                        nextState = excEpc;
                endcase
            end
            aluExec:
                nextState = aluCheck;
            aluCheck:
                nextState = overflow ? excEpc : aluWrite;
            addmAddr: begin
                nextState = addmRead;
                timerLoad = 1'b1;
            end
            addmRead: begin
                if (timerDone) begin
                    nextState = addmMdr;
                end
            end
            addmMdr:
                nextState = addmAdd;
            addmAdd:
                nextState = addmWrite;
            divmReadA: begin
                if (timerDone) begin
                    nextState = divmMdrA;
                end
            end
            divmMdrA: begin
                nextState = divmReadB;
                timerLoad = 1'b1;
            end
            divmReadB: begin
                // Second operand stays on the memory bus while the divider runs
                if (timerDone) begin
                    nextState = divmRun;
                    timerLoad = 1'b1;
                    loadDiv = 1'b1;
                end
            end
            divmRun: begin
                if (timerDone) begin
                    nextState = divmWrite;
                end
            end
            excEpc:
                nextState = excPc;
            // Last step of every instruction goes back to fetch
            aluWrite, breakPc, rtePc, addmWrite, divmWrite, excPc: begin
                nextState = fetchRead;
                timerLoad = 1'b1;
            end
            default:
                nextState = stReset;
        endcase
    end

    assign timerCount = loadDiv ? DivCount : MemCount;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= stReset;
        end else begin
            state <= nextState;
        end
    end

    // Delayed copy, so downstream logic sees reset for one more cycle
    always_ff @(posedge clock) begin
        resetOut <= reset;
    end

    stateLegal: assert property (
        @(posedge clock) disable iff (reset)
        state inside {[stReset:excPc]}
    );

    resetExitsToFetch: assert property (
        @(posedge clock) disable iff (reset)
        (state == stReset) |=> (state == fetchRead)
    );

endmodule

// File: rtl/controlWordEncoder.sv
`timescale 1ns/1ps

module controlWordEncoder (
    input ctrlPkg::ctrlState_t state,
    input isaPkg::instrClass_t instrClass,
    output ctrlPkg::writeEnables_t writes,
    output ctrlPkg::muxSelects_t selects,
    output ctrlPkg::aluControl_t aluCtrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    aluOp_t execOp;
    exCause_t trapCause;

    // Class is stable from the IR load until the next fetch
    assign execOp = (instrClass == classSub) ? aluSub : aluAdd;
    assign trapCause = (instrClass == classIllegal) ? causeIllegal : causeOverflow;

    always_comb begin
        writes = '0;
        selects = '0;
        aluCtrl = '0;

        case (state)
            fetchRead, fetchLoad: begin
                // PC+4 is computed during the whole fetch
                selects.iorD = pcAddr;
                selects.aluSrcA = srcPc;
                selects.aluSrcB = srcFour;
                selects.pcSource = pcAluResult;
                aluCtrl.aluOp = aluAdd;
                if (state == fetchLoad) begin
                    writes.irWrite = 1'b1;
                    writes.pcWrite = 1'b1;
                end
            end
            decode: begin
                // Branch target into aluOut, register operands into A and B
                writes.regAWrite = 1'b1;
                writes.regBWrite = 1'b1;
                writes.aluOutWrite = 1'b1;
                selects.aluSrcA = srcPc;
                selects.aluSrcB = srcOffset;
                aluCtrl.aluOp = aluAdd;
            end
            aluExec, aluCheck: begin
                // Operands held in aluCheck so the overflow flag stays valid
                writes.aluOutWrite = (state == aluExec);
                selects.aluSrcA = srcRegA;
                selects.aluSrcB = srcRegB;
                aluCtrl.aluOp = execOp;
            end
            aluWrite, addmWrite: begin
                writes.regWrite = 1'b1;
                selects.regDst = (state == aluWrite) ? dstRd : dstRt;
                selects.dataSrc = dataAluOut;
            end
            breakPc: begin
                writes.pcWrite = 1'b1;
                selects.aluSrcA = srcPc;
                selects.aluSrcB = srcFour;
                selects.pcSource = pcAluResult;
                aluCtrl.aluOp = aluSub;
            end
            rtePc: begin
                writes.pcWrite = 1'b1;
                selects.pcSource = pcEpc;
            end
            addmAddr: begin
                writes.aluOutWrite = 1'b1;
                selects.aluSrcA = srcRegA;
                selects.aluSrcB = srcRegB;
                aluCtrl.aluOp = aluAdd;
            end
            addmRead, addmMdr: begin
                writes.mdrWrite = (state == addmMdr);
                selects.iorD = aluOutAddr;
            end
            addmAdd: begin
                writes.aluOutWrite = 1'b1;
                selects.aluSrcA = srcMdr;
                selects.aluSrcB = srcRegB;
                aluCtrl.aluOp = aluAdd;
            end
            divmReadA, divmMdrA: begin
                writes.mdrWrite = (state == divmMdrA);
                selects.iorD = regAAddr;
            end
            divmReadB:
                selects.iorD = regBAddr;
            divmRun, divmWrite: begin
                selects.iorD = regBAddr;
                selects.mdSrcA = 1'b1;
                selects.mdSrcB = 1'b1;
                aluCtrl.mdRun = (state == divmRun);
                writes.hiWrite = (state == divmWrite);
                writes.loWrite = (state == divmWrite);
            end
            excEpc, excPc: begin
                // EPC gets the address of the trapping instruction
                writes.epcWrite = (state == excEpc);
                writes.pcWrite = (state == excPc);
                selects.aluSrcA = srcPc;
                selects.aluSrcB = srcFour;
                selects.pcSource = pcVector;
                aluCtrl.aluOp = aluSub;
                aluCtrl.exCause = trapCause;
            end
            default: begin
            end
        endcase
    end

    // None of the supported instructions stores to memory
    always_comb begin
        assert (writes.memWrite == 1'b0)
            else $error("memWrite raised in state %s", state.name());
    end

endmodule

// File: rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit #(
    parameter int MemWaitCycles = 2,
    parameter int DivCycles = 32
) (
    input logic clock,
    input logic reset,
    input isaPkg::opcode_t opcode,
    input isaPkg::funct_t funct,
    input logic overflow,
    output ctrlPkg::writeEnables_t writes,
    output ctrlPkg::muxSelects_t selects,
    output ctrlPkg::aluControl_t aluCtrl,
    output logic resetOut
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrClass_t instrClass;
    ctrlState_t state;
    logic timerLoad;
    logic timerDone;
    logic [TimerWidth-1:0] timerCount;

    instructionDecoder decoder0 (
        .opcode(opcode),
        .funct(funct),
        .instrClass(instrClass)
    );

    waitTimer timer0 (
        .clock(clock),
        .reset(reset),
        .timerLoad(timerLoad),
        .timerCount(timerCount),
        .timerDone(timerDone)
    );

    controlSequencer #(
        .MemWaitCycles(MemWaitCycles),
        .DivCycles(DivCycles)
    ) sequencer0 (
        .clock(clock),
        .reset(reset),
        .instrClass(instrClass),
        .overflow(overflow),
        .timerDone(timerDone),
        .timerLoad(timerLoad),
        .timerCount(timerCount),
        .state(state),
        .resetOut(resetOut)
    );

    controlWordEncoder encoder0 (
        .state(state),
        .instrClass(instrClass),
        .writes(writes),
        .selects(selects),
        .aluCtrl(aluCtrl)
    );

endmodule

// File: include/controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Expected class of an opcode and funct pair
function automatic isaPkg::instrClass_t classOf(isaPkg::opcode_t op, isaPkg::funct_t fn);
    if (op == isaPkg::OpAddm) begin
        return isaPkg::classAddm;
    end
    if (op != isaPkg::OpRType) begin
        return isaPkg::classIllegal;
    end
    case (fn)
        isaPkg::FunctAdd: return isaPkg::classAdd;
        isaPkg::FunctSub: return isaPkg::classSub;
        isaPkg::FunctBreak: return isaPkg::classBreak;
        isaPkg::FunctRte: return isaPkg::classRte;
        isaPkg::FunctDivm: return isaPkg::classDivm;
        default: return isaPkg::classIllegal;
    endcase
endfunction

// Cycles from the end of decode to the next fetch
function automatic int execLength(isaPkg::instrClass_t cls, logic ovf, int memWait,
                                  int divCycles);
    case (cls)
        isaPkg::classAdd, isaPkg::classSub: return ovf ? 4 : 3;
        isaPkg::classBreak, isaPkg::classRte: return 1;
        isaPkg::classAddm: return memWait + 4;
        isaPkg::classDivm: return 2 * memWait + divCycles + 2;
        default: return 2;
    endcase
endfunction

// Cycles between two irWrite pulses
function automatic int irGapLength(isaPkg::instrClass_t cls, logic ovf, int memWait,
                                   int divCycles);
    return memWait + 1 + execLength(cls, ovf, memWait, divCycles);
endfunction

// ALU operation of the add or sub execute step
function automatic ctrlPkg::aluOp_t execAluOp(isaPkg::instrClass_t cls);
    case (cls)
        isaPkg::classAdd: return ctrlPkg::aluAdd;
        isaPkg::classSub: return ctrlPkg::aluSub;
        default: return ctrlPkg::aluLoad;
    endcase
endfunction

// Cause shown while an exception is taken
function automatic ctrlPkg::exCause_t causeOf(isaPkg::instrClass_t cls, logic ovf);
    if (cls == isaPkg::classIllegal) begin
        return ctrlPkg::causeIllegal;
    end
    if ((cls == isaPkg::classAdd || cls == isaPkg::classSub) && ovf) begin
        return ctrlPkg::causeOverflow;
    end
    return ctrlPkg::causeNone;
endfunction

`endif

// File: test/tbControlUnit.sv
`timescale 1ns/1ps

module tbControlUnit;
    import isaPkg::*;
    import ctrlPkg::*;

    `include "controlModel.svh"

    localparam int MemWaitCycles = 2;
    localparam int DivCycles = 32;
    localparam int Instructions = 200;
    localparam int WatchdogCycles = Instructions * (2 * MemWaitCycles + DivCycles + 12) + 20;

    logic clock;
    logic reset;
    opcode_t opcode;
    funct_t funct;
    logic overflow;
    writeEnables_t writes;
    muxSelects_t selects;
    aluControl_t aluCtrl;
    logic resetOut;

    logic [31:0] lfsrState;
    int errorCount;
    int testsRun;
    int testsFailed;

    // Events seen during one instruction
    int regWrites;
    int mdrWrites;
    int epcWrites;
    int execPcWrites;
    int mdRunCycles;
    int hiLoPulses;
    logic epcPrev;

    controlUnit #(
        .MemWaitCycles(MemWaitCycles),
        .DivCycles(DivCycles)
    ) dut0 (
        .clock(clock),
        .reset(reset),
        .opcode(opcode),
        .funct(funct),
        .overflow(overflow),
        .writes(writes),
        .selects(selects),
        .aluCtrl(aluCtrl),
        .resetOut(resetOut)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #(WatchdogCycles * 10);
        $display("Timeout: the DUT stopped producing instruction fetches in time");
        $display("Regression failed");
        $finish;
    end

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] nextLfsr(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int randomBits(int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsrState = nextLfsr(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    task automatic reportFail(string msg);
        errorCount++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endtask

    task automatic expectCount(string what, int got, int want);
        if (got != want) begin
            reportFail($sformatf("%s count %0d, expected %0d", what, got, want));
        end
    endtask

    task automatic finishTest(string name, int failsBefore);
        testsRun++;
        if (errorCount > failsBefore) begin
            testsFailed++;
            $display("%s: FAILED", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // Weights out of 32, the last slot is a random encoding
    task automatic pickInstruction(output opcode_t op, output funct_t fn);
        int roll;
        roll = randomBits(5);
        op = OpRType;
        fn = FunctAdd;
        if (roll < 6) begin
            fn = FunctAdd;
        end else if (roll < 12) begin
            fn = FunctSub;
        end else if (roll < 15) begin
            fn = FunctBreak;
        end else if (roll < 18) begin
            fn = FunctRte;
        end else if (roll < 23) begin
            op = OpAddm;
            fn = funct_t'(randomBits(6));
        end else if (roll < 27) begin
            fn = FunctDivm;
        end else begin
            op = opcode_t'(randomBits(6));
            fn = funct_t'(randomBits(6));
        end
    endtask

    task automatic clearCounts();
        regWrites = 0;
        mdrWrites = 0;
        epcWrites = 0;
        execPcWrites = 0;
        mdRunCycles = 0;
        hiLoPulses = 0;
        epcPrev = 1'b0;
    endtask

    task automatic checkReset();
        int failsBefore;
        int edges;
        failsBefore = errorCount;
        repeat (10) begin
            @(negedge clock);
            if (writes != '0 || aluCtrl != '0 || resetOut !== 1'b1) begin
                reportFail("control outputs not idle while reset is high");
            end
        end
        @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (writes != '0 || resetOut !== 1'b1) begin
            reportFail("control outputs wrong in the cycle after reset release");
        end
        edges = 0;
        do begin
            @(posedge clock);
            edges++;
            @(negedge clock);
            if (edges == 1 && resetOut !== 1'b0) begin
                reportFail("resetOut still high two cycles after release");
            end
        end while (!writes.irWrite && edges < 4 * MemWaitCycles + 8);
        if (edges != MemWaitCycles + 1) begin
            reportFail($sformatf("first irWrite after %0d cycles, expected %0d",
                                 edges, MemWaitCycles + 1));
        end
        finishTest("Reset", failsBefore);
    endtask

    // One sampled cycle, nextOvf is the overflow level for the coming cycle
    task automatic observeCycle(instrClass_t cls, logic ovf, int gap, int expGap,
                                output logic nextOvf);
        nextOvf = 1'b0;
        if (writes.memWrite) begin
            reportFail("memWrite is high");
        end
        if (gap == 1 && !(writes.regAWrite && writes.regBWrite && writes.aluOutWrite)) begin
            reportFail("decode does not load A, B and aluOut");
        end
        if (gap == 2 && (cls == classAdd || cls == classSub)) begin
            if (!writes.aluOutWrite || selects.aluSrcA != srcRegA || selects.aluSrcB != srcRegB) begin
                reportFail("ALU execute step missing after decode");
            end else begin
                if (aluCtrl.aluOp != execAluOp(cls)) begin
                    reportFail($sformatf("aluOp %s for %s", aluCtrl.aluOp.name(), cls.name()));
                end
                nextOvf = ovf;
            end
        end
        // Last M cycles before the irWrite are the fetch read
        if (gap > expGap - MemWaitCycles && gap <= expGap) begin
            if (selects.iorD != pcAddr || selects.aluSrcA != srcPc
                    || selects.aluSrcB != srcFour || aluCtrl.aluOp != aluAdd
                    || selects.pcSource != pcAluResult) begin
                reportFail("fetch does not read at the PC while computing PC+4");
            end
        end
        if (cls == classAddm && gap > 2 && gap <= MemWaitCycles + 2
                && selects.iorD != aluOutAddr) begin
            reportFail("addm read not addressed by aluOut");
        end
        if (cls == classDivm && gap > 1 && gap <= MemWaitCycles + 1
                && selects.iorD != regAAddr) begin
            reportFail("divm first read not addressed by register A");
        end
        if (cls == classDivm && gap > MemWaitCycles + 2 && gap <= 2 * MemWaitCycles + 2
                && selects.iorD != regBAddr) begin
            reportFail("divm second read not addressed by register B");
        end
        if (epcPrev && !(writes.pcWrite && selects.pcSource == pcVector
                         && aluCtrl.exCause == causeOf(cls, ovf))) begin
            reportFail("epcWrite not followed by pcWrite to the exception vector");
        end
        if (writes.irWrite) begin
            if (!writes.pcWrite) begin
                reportFail("irWrite without pcWrite");
            end
        end else if (writes.pcWrite) begin
            execPcWrites++;
            if (cls == classBreak && (selects.pcSource != pcAluResult || aluCtrl.aluOp != aluSub)) begin
                reportFail("break does not write PC-4");
            end
            if (cls == classRte && selects.pcSource != pcEpc) begin
                reportFail("rte does not load the PC from EPC");
            end
        end
        if (writes.regWrite) begin
            regWrites++;
            if (selects.dataSrc != dataAluOut) begin
                reportFail("regWrite without dataAluOut");
            end
            if (cls == classAddm && (selects.regDst != dstRt || mdrWrites != 1)) begin
                reportFail("addm register write without dstRt or before mdrWrite");
            end
            if (cls != classAddm && selects.regDst != dstRd) begin
                reportFail("add or sub register write without dstRd");
            end
        end
        if (writes.mdrWrite) begin
            mdrWrites++;
        end
        if (writes.epcWrite) begin
            epcWrites++;
            if (aluCtrl.exCause != causeOf(cls, ovf)) begin
                reportFail($sformatf("exCause %s for %s", aluCtrl.exCause.name(), cls.name()));
            end
        end
        if (aluCtrl.mdRun) begin
            mdRunCycles++;
            if (hiLoPulses != 0) begin
                reportFail("mdRun high after the HI and LO write");
            end
            if (!selects.mdSrcA || !selects.mdSrcB) begin
                reportFail("divider inputs not taken from memory while mdRun is high");
            end
        end
        if (writes.hiWrite || writes.loWrite) begin
            hiLoPulses++;
            if (writes.hiWrite != writes.loWrite) begin
                reportFail("hiWrite and loWrite not together");
            end
            if (mdRunCycles != DivCycles) begin
                reportFail($sformatf("HI and LO written after %0d mdRun cycles", mdRunCycles));
            end
        end
        epcPrev = writes.epcWrite;
    endtask

    task automatic runInstruction(int index);
        opcode_t op;
        funct_t fn;
        instrClass_t cls;
        logic ovf;
        logic nextOvf;
        logic arith;
        logic trap;
        int expGap;
        int gap;
        int failsBefore;

        pickInstruction(op, fn);
        ovf = (randomBits(2) == 3);
        cls = classOf(op, fn);
        arith = (cls == classAdd || cls == classSub);
        trap = (cls == classIllegal) || (arith && ovf);
        expGap = irGapLength(cls, ovf, MemWaitCycles, DivCycles);
        failsBefore = errorCount;
        clearCounts();
        gap = 0;
        nextOvf = 1'b0;

        // IR loads at this edge, so the new fields go out now
        @(posedge clock);
        opcode <= op;
        funct <= fn;
        overflow <= 1'b0;
        do begin
            @(negedge clock);
            gap++;
            observeCycle(cls, ovf, gap, expGap, nextOvf);
            if (gap == expGap + 1 && !writes.irWrite) begin
                reportFail($sformatf("no irWrite after %0d cycles", expGap));
            end
            if (!writes.irWrite) begin
                @(posedge clock);
                overflow <= nextOvf;
            end
        end while (!writes.irWrite);

        // The count includes the irWrite cycle itself
        if (gap - 1 != expGap) begin
            reportFail($sformatf("irWrite gap %0d, expected %0d", gap - 1, expGap));
        end
        expectCount("regWrite", regWrites, ((arith && !ovf) || cls == classAddm) ? 1 : 0);
        expectCount("epcWrite", epcWrites, trap ? 1 : 0);
        expectCount("execution pcWrite", execPcWrites,
                    (trap || cls == classBreak || cls == classRte) ? 1 : 0);
        expectCount("mdrWrite", mdrWrites, (cls == classAddm || cls == classDivm) ? 1 : 0);
        expectCount("mdRun cycle", mdRunCycles, (cls == classDivm) ? DivCycles : 0);
        expectCount("HI and LO write", hiLoPulses, (cls == classDivm) ? 1 : 0);
        finishTest($sformatf("Instruction %0d %s ovf=%0b gap=%0d", index, cls.name(), ovf,
                             gap - 1),
                   failsBefore);
    endtask

    initial begin
        reset = 1'b1;
        opcode = OpRType;
        funct = FunctAdd;
        overflow = 1'b0;
        lfsrState = 32'had6;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        clearCounts();

        checkReset();
        for (int i = 0; i < Instructions; i++) begin
            runInstruction(i);
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/instructionDecoder.sv
rtl/waitTimer.sv
rtl/controlSequencer.sv
rtl/controlWordEncoder.sv
rtl/controlUnit.sv
test/tbControlUnit.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tbControlUnit \
    -Mdir obj_dir -o simControlUnit || { echo "Verilator build failed"; exit 1; }
output="$(./obj_dir/simControlUnit 2>&1)"
echo "$output"
echo "$output" | grep -qF "Regression passed" && exit 0 || exit 1
